//--- sources.f
+incdir+rtl
rtl/noc_pkg.sv
rtl/noc_ctrl.sv
rtl/ifmap_line_buffer.sv
rtl/read_ptr_gen.sv
rtl/diag_route.sv
rtl/ifmap_noc.sv
tests/ifmap_noc_props.sv
tests/ifmap_noc_tb.sv

//--- run.sh
#!/bin/sh
# build the ifmap NoC testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module ifmap_noc_tb -o ifmap_noc_sim -f sources.f \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/ifmap_noc_sim)
echo "$out"
echo "$out" | grep -qx "Regression passed" && exit 0 || exit 1

//--- tests/ifmap_patterns.txt
// per test: layer mode complete_count, then lines 0 to 7 as 128-bit words
// layer 0 is wide and 1 shared, mode is the pad byte count, byte 0 is the last hex pair
0 0 1
0f0e0d0c0b0a09080706050403020100
1f1e1d1c1b1a19181716151413121110
2f2e2d2c2b2a29282726252423222120
3f3e3d3c3b3a39383736353433323130
4f4e4d4c4b4a49484746454443424140
5f5e5d5c5b5a59585756555453525150
6f6e6d6c6b6a69686766656463626160
7f7e7d7c7b7a79787776757473727170
1 1 2
8f8e8d8c8b8a89888786858483828180
9f9e9d9c9b9a99989796959493929190
afaeadacabaaa9a8a7a6a5a4a3a2a1a0
bfbebdbcbbbab9b8b7b6b5b4b3b2b1b0
cfcecdcccbcac9c8c7c6c5c4c3c2c1c0
dfdedddcdbdad9d8d7d6d5d4d3d2d1d0
efeeedecebeae9e8e7e6e5e4e3e2e1e0
fffefdfcfbfaf9f8f7f6f5f4f3f2f1f0
0 2 1
deadbeef0123456789abcdef0badf00d
cafebabe112233445566778899aabbcc
13579bdf2468ace0fdb975310eca8642
a1b2c3d4e5f60718293a4b5c6d7e8f90
600df00d5eed1234b16b00b57e57da7a
0f0f0f0ff0f0f0f055aa55aa33cc33cc
123456789abcdef0876543210fedcba9
ffeeddccbbaa99887766554433221100
1 1 2
31415926535897932384626433832795
27182818284590452353602874713526
14142135623730950488016887242096
17320508075688772935274463415058
22360679774997896964091736687311
16180339887498948482045868343656
57721566490153286060651209008240
69314718055994530941723212145817

//--- tests/ifmap_noc_tb.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module ifmap_noc_tb import noc_pkg::*; ();

    localparam int NUM_TESTS      = 4;
    localparam int REC_WORDS      = 3 + `NOC_NUM_LINES;
    localparam int NUM_PKTS       = `NOC_NUM_LINES * `NOC_ELEMS;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * (NUM_PKTS * 8 + 20) + 8;

    logic                               clk;
    logic                               rst_n;
    logic                               load_valid;
    logic                               load_ready;
    layer_t                             load_layer;
    pad_mode_t                          load_mode;
    line_word_t [`NOC_NUM_LINES-1:0]    load_lines;
    logic [`NOC_NUM_DIAG-1:0]           pe_full;
    logic                               conv_complete;
    logic                               out_valid;
    logic [31:0]                        out_data;
    logic [`NOC_PTR_W-1:0]              out_line;
    logic [1:0]                         out_elem;
    logic [`NOC_NUM_DIAG-1:0]           out_bus;
    logic                               free_buffer;

    logic [127:0]   pat_mem [0:NUM_TESTS*REC_WORDS-1];
    logic [127:0]   exp_line [0:`NOC_NUM_LINES-1];
    logic [31:0]    lcg_state;
    int             cycle_cnt = 0;
    int             err_cnt = 0;
    int             test_err = 0;
    int             check_cnt = 0;
    int             fail_tests = 0;

    ifmap_noc DUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load_ready    (load_ready),
        .load_layer    (load_layer),
        .load_mode     (load_mode),
        .load_lines    (load_lines),
        .pe_full       (pe_full),
        .conv_complete (conv_complete),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_line      (out_line),
        .out_elem      (out_elem),
        .out_bus       (out_bus),
        .free_buffer   (free_buffer)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_cnt);
            $display("Regression failed");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // each bus reads full when its two state bits are both zero
    function automatic logic [`NOC_NUM_DIAG-1:0] full_from(input logic [31:0] s);
        logic [`NOC_NUM_DIAG-1:0] f;
        for (int b = 0; b < `NOC_NUM_DIAG; b++) begin
            f[b] = (s[31-2*b -: 2] == 2'b00);
        end
        return f;
    endfunction

    // low pad bytes are zero, the rest move up and the top bytes drop out
    function automatic logic [127:0] pad_line(input logic [127:0] raw, input int pad);
        logic [127:0] res;
        res = '0;
        for (int k = pad; k < `NOC_LINE_BYTES; k++) begin
            res[k*8 +: 8] = raw[(k-pad)*8 +: 8];
        end
        return res;
    endfunction

    function automatic logic [`NOC_NUM_DIAG-1:0] route_mask(input layer_t lyr, input int line);
        logic [`NOC_NUM_DIAG-1:0] m;
        m = '0;
        m[line % `NOC_NUM_DIAG] = 1'b1;
        if (lyr == LAYER_SHARED) begin
            m[(line + 1) % `NOC_NUM_DIAG] = 1'b1;
        end
        return m;
    endfunction

    task automatic compare(input string name, input int pkt, input logic [127:0] got,
                           input logic [127:0] exp);
        check_cnt++;
        if (got !== exp) begin
            $display("ERR %s: got %0h expected %0h at packet %0d", name, got, exp, pkt);
            test_err++;
        end
    endtask

    task automatic run_test(input int t);
        layer_t                     lyr;
        pad_mode_t                  md;
        int                         cpl_need;
        int                         base;
        int                         pkts;
        int                         frees;
        int                         cyc;
        logic [`NOC_NUM_DIAG-1:0]   mask;
        base = t * REC_WORDS;
        lyr = layer_t'(pat_mem[base][0]);
        md = pad_mode_t'(pat_mem[base+1][1:0]);
        cpl_need = int'(pat_mem[base+2][3:0]);
        test_err = 0;
        pkts = 0;
        frees = 0;
        cyc = 0;
        // expected buffer contents after padding with this load's mode
        for (int l = 0; l < `NOC_NUM_LINES; l++) begin
            exp_line[l] = pad_line(pat_mem[base+3+l], int'(md));
        end

        @(negedge clk);
        load_valid = 1'b1;
        load_layer = lyr;
        load_mode = md;
        for (int l = 0; l < `NOC_NUM_LINES; l++) begin
            load_lines[l] = pat_mem[base+3+l];
        end
        do begin
            @(posedge clk);
        end while (!load_ready);

        // a second load stays pending with other contents until the free
        @(negedge clk);
        load_layer = (lyr == LAYER_WIDE) ? LAYER_SHARED : LAYER_WIDE;
        load_mode = PAD_TWO;
        for (int l = 0; l < `NOC_NUM_LINES; l++) begin
            load_lines[l] = ~pat_mem[base+3+l];
        end

        while (pkts < NUM_PKTS) begin
            if (cyc != 0) begin
                @(negedge clk);
            end
            lcg_state = lcg_next(lcg_state);
            pe_full = full_from(lcg_state);
            conv_complete = (cyc == 2);
            @(posedge clk);
            cyc++;
            compare("load_ready", pkts, 128'(load_ready), 128'(0));
            compare("free_buffer", pkts, 128'(free_buffer), 128'(0));
            mask = route_mask(lyr, pkts % `NOC_NUM_LINES);
            if (out_valid) begin
                compare("out_line", pkts, 128'(out_line), 128'(pkts % `NOC_NUM_LINES));
                compare("out_elem", pkts, 128'(out_elem), 128'(pkts / `NOC_NUM_LINES));
                compare("out_data", pkts, 128'(out_data),
                        128'(exp_line[pkts % `NOC_NUM_LINES][(pkts / `NOC_NUM_LINES)*32 +: 32]));
                compare("out_bus", pkts, 128'(out_bus), 128'(mask));
                if ((mask & pe_full) != '0) begin
                    $display("test %0d: packet %0d went out while a target bus was full", t, pkts);
                    test_err++;
                end
                pkts++;
            end else begin
                compare("out_bus", pkts, 128'(out_bus), 128'(0));
                if ((mask & pe_full) == '0) begin
                    $display("test %0d: stream stalled at packet %0d with no bus full", t, pkts);
                    test_err++;
                end
            end
        end

        for (int p = 1; p <= cpl_need; p++) begin
            @(negedge clk);
            conv_complete = 1'b0;
            @(posedge clk);
            compare("out_valid", pkts, 128'(out_valid), 128'(0));
            compare("load_ready", pkts, 128'(load_ready), 128'(0));
            frees += int'(free_buffer);
            @(negedge clk);
            conv_complete = 1'b1;
            @(posedge clk);
            frees += int'(free_buffer);
        end
        @(negedge clk);
        conv_complete = 1'b0;
        load_valid = 1'b0;
        @(posedge clk);
        compare("free_buffer", pkts, 128'(free_buffer), 128'(1));
        compare("load_ready", pkts, 128'(load_ready), 128'(1));
        frees += int'(free_buffer);
        @(posedge clk);
        compare("free_buffer", pkts, 128'(free_buffer), 128'(0));
        frees += int'(free_buffer);

        if (frees != 1) begin
            $display("test %0d: free_buffer pulsed %0d times instead of once", t, frees);
            test_err++;
        end
        $display("test %0d layer %0d mode %0d: %0d packets in %0d cycles, %0d errors",
                 t, lyr, md, pkts, cyc, test_err);
        err_cnt += test_err;
        if (test_err != 0) begin
            fail_tests++;
        end
    endtask

    initial begin
        rst_n = 1'b0;
        load_valid = 1'b0;
        load_layer = LAYER_WIDE;
        load_mode = PAD_NONE;
        load_lines = '0;
        pe_full = '0;
        conv_complete = 1'b0;
        lcg_state = 32'h2184b614;
        $readmemh("tests/ifmap_patterns.txt", pat_mem);
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(posedge clk);
        compare("load_ready", 0, 128'(load_ready), 128'(1));
        compare("out_valid", 0, 128'(out_valid), 128'(0));
        compare("free_buffer", 0, 128'(free_buffer), 128'(0));
        $display("reset check: %0d errors", test_err);
        err_cnt += test_err;
        for (int t = 0; t < NUM_TESTS; t++) begin
            run_test(t);
        end
        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 NUM_TESTS, fail_tests, check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- tests/ifmap_noc_props.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module ifmap_noc_props (
    input logic                         clk,
    input logic                         rst_n,
    input logic                         load_ready,
    input logic                         stream_en,
    input logic                         out_valid,
    input logic [`NOC_NUM_DIAG-1:0]     out_bus,
    input logic [`NOC_NUM_DIAG-1:0]     pe_full,
    input logic                         free_buffer
);

    // release is a single cycle strobe
    free_single: assert property (@(posedge clk) disable iff (!rst_n)
        free_buffer |=> !free_buffer)
        else $error("free_buffer stayed high for more than one cycle");

    no_full_bus: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> ((out_bus & pe_full) == '0))
        else $error("packet sent onto a full bus");

    // no new buffer may be taken while the current one streams
    ready_low_stream: assert property (@(posedge clk) disable iff (!rst_n)
        stream_en |-> !load_ready)
        else $error("load_ready high while streaming");

    valid_has_bus: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |-> (out_bus != '0))
        else $error("valid packet with an empty bus mask");

endmodule

bind ifmap_noc ifmap_noc_props u_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .load_ready  (load_ready),
    .stream_en   (stream_en),
    .out_valid   (out_valid),
    .out_bus     (out_bus),
    .pe_full     (pe_full),
    .free_buffer (free_buffer)
);

//--- rtl/ifmap_noc.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module ifmap_noc import noc_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_valid,
    output logic                                load_ready,
    input  layer_t                              load_layer,
    input  pad_mode_t                           load_mode,
    input  line_word_t [`NOC_NUM_LINES-1:0]     load_lines,
    input  logic [`NOC_NUM_DIAG-1:0]            pe_full,
    input  logic                                conv_complete,
    output logic                                out_valid,
    output logic [`NOC_ELEM_BYTES*8-1:0]        out_data,
    output logic [`NOC_PTR_W-1:0]               out_line,
    output logic [$clog2(`NOC_ELEMS)-1:0]       out_elem,
    output logic [`NOC_NUM_DIAG-1:0]            out_bus,
    output logic                                free_buffer
);

    logic                           load_en;
    layer_t                         layer;
    pad_mode_t                      mode;
    logic                           stream_en;
    logic                           stream_done;
    logic                           line_ok;
    logic                           advance;
    logic [`NOC_NUM_DIAG-1:0]       bus_mask;

    noc_ctrl u_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .load_valid    (load_valid),
        .load_layer    (load_layer),
        .load_mode     (load_mode),
        .conv_complete (conv_complete),
        .stream_done   (stream_done),
        .load_ready    (load_ready),
        .load_en       (load_en),
        .layer         (layer),
        .mode          (mode),
        .stream_en     (stream_en),
        .free_buffer   (free_buffer)
    );

    ifmap_line_buffer u_buf (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_en    (load_en),
        .mode       (mode),
        .load_lines (load_lines),
        .rd_line    (out_line),
        .rd_elem    (out_elem),
        .rd_data    (out_data)
    );

    read_ptr_gen u_ptr (
        .clk         (clk),
        .rst_n       (rst_n),
        .load_en     (load_en),
        .advance     (advance),
        .line_ptr    (out_line),
        .elem_ptr    (out_elem),
        .stream_done (stream_done)
    );

    diag_route u_route (
        .layer    (layer),
        .line_ptr (out_line),
        .pe_full  (pe_full),
        .bus_mask (bus_mask),
        .line_ok  (line_ok)
    );

    // a packet leaves only while streaming and its buses have room
    assign advance   = stream_en & line_ok;
    assign out_valid = advance;
    assign out_bus   = out_valid ? bus_mask : '0;

endmodule

//--- rtl/diag_route.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module diag_route import noc_pkg::*; (
    input  layer_t                      layer,
    input  logic [`NOC_PTR_W-1:0]       line_ptr,
    input  logic [`NOC_NUM_DIAG-1:0]    pe_full,
    output logic [`NOC_NUM_DIAG-1:0]    bus_mask,
    output logic                        line_ok
);

    localparam logic [`NOC_PTR_W-1:0] NUM_DIAG = `NOC_PTR_W'(`NOC_NUM_DIAG);

    logic [`NOC_PTR_W-1:0]    diag_idx;
    logic [`NOC_PTR_W-1:0]    diag_next;
    logic [`NOC_NUM_DIAG-1:0] own_bus;
    logic [`NOC_NUM_DIAG-1:0] next_bus;

    // line index folded onto the bus count, lines never exceed twice the bus count
    assign diag_idx = (line_ptr >= NUM_DIAG) ? line_ptr - NUM_DIAG : line_ptr;

    // neighbouring diagonal, wrapping back to bus 0
    assign diag_next = (diag_idx == NUM_DIAG - 1'b1) ? '0 : diag_idx + 1'b1;

    assign own_bus  = `NOC_NUM_DIAG'(1) << diag_idx;
    assign next_bus = `NOC_NUM_DIAG'(1) << diag_next;

    // wide layer feeds one diagonal per line, shared layer also feeds the next one
    always_comb begin
        case (layer)
            LAYER_SHARED: bus_mask = own_bus | next_bus;
            default:      bus_mask = own_bus;
        endcase
    end

    // a line may go only if none of its target buses is full
    assign line_ok = ~|(bus_mask & pe_full);

endmodule

//--- rtl/read_ptr_gen.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module read_ptr_gen (
    input  logic                            clk,
    input  logic                            rst_n,
    input  logic                            load_en,
    input  logic                            advance,
    output logic [`NOC_PTR_W-1:0]           line_ptr,
    output logic [$clog2(`NOC_ELEMS)-1:0]   elem_ptr,
    output logic                            stream_done
);

    localparam logic [`NOC_PTR_W-1:0]         LAST_LINE = `NOC_PTR_W'(`NOC_NUM_LINES - 1);
    localparam logic [$clog2(`NOC_ELEMS)-1:0] LAST_ELEM = $clog2(`NOC_ELEMS)'(`NOC_ELEMS - 1);

    logic line_wrap;

    assign line_wrap = (line_ptr == LAST_LINE);

    // last packet of the buffer is going out this cycle
    assign stream_done = advance && line_wrap && (elem_ptr == LAST_ELEM);

    // lines are the inner loop, elements the outer one
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (load_en) begin
            line_ptr <= '0;
            elem_ptr <= '0;
        end else if (advance) begin
            if (line_wrap) begin
                line_ptr <= '0;
                elem_ptr <= elem_ptr + 1'b1;
            end else begin
                line_ptr <= line_ptr + 1'b1;
            end
        end
    end

endmodule

//--- rtl/ifmap_line_buffer.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module ifmap_line_buffer import noc_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                load_en,
    input  pad_mode_t                           mode,
    input  line_word_t [`NOC_NUM_LINES-1:0]     load_lines,
    input  logic [`NOC_PTR_W-1:0]               rd_line,
    input  logic [$clog2(`NOC_ELEMS)-1:0]       rd_elem,
    output logic [`NOC_ELEM_BYTES*8-1:0]        rd_data
);

    line_word_t [`NOC_NUM_LINES-1:0] lines;
    line_word_t                      cur_line;
    line_word_t                      padded;
    int unsigned                     pad;

    // mode is latched together with the lines, so it stays valid for the whole buffer
    assign pad      = int'(mode);
    assign cur_line = lines[rd_line];

    // shift the selected line up by the pad, zero fill at the bottom, top bytes fall off
    always_comb begin
        for (int k = 0; k < `NOC_LINE_BYTES; k++) begin
            if (k < pad) begin
                padded.bytes[k] = 8'h00;
            end else begin
                padded.bytes[k] = cur_line.bytes[k - pad];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lines <= '0;
        end else if (load_en) begin
            lines <= load_lines;
        end
    end

    // element select through the element view of the union
    assign rd_data = padded.elems[rd_elem];

endmodule

//--- rtl/noc_ctrl.sv
`timescale 1ns/10ps
`include "noc_consts.svh"

module noc_ctrl import noc_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      load_valid,
    input  layer_t    load_layer,
    input  pad_mode_t load_mode,
    input  logic      conv_complete,
    input  logic      stream_done,
    output logic      load_ready,
    output logic      load_en,
    output layer_t    layer,
    output pad_mode_t mode,
    output logic      stream_en,
    output logic      free_buffer
);

    localparam logic [1:0] ST_IDLE   = 2'd0;
    localparam logic [1:0] ST_STREAM = 2'd1;
    localparam logic [1:0] ST_WAIT   = 2'd2;

    logic [1:0] state;
    logic [1:0] cpl_cnt;
    logic [1:0] cpl_target;
    logic       cpl_last;

    // buffer accepts a new load only when it is empty
    assign load_ready = (state == ST_IDLE);
    assign load_en    = load_valid & load_ready;
    assign stream_en  = (state == ST_STREAM);

    assign cpl_target = (layer == LAYER_SHARED) ? 2'(`NOC_CPL_SHARED) : 2'(`NOC_CPL_WIDE);

    // the pulse that brings the count up to the layer target releases the buffer
    assign cpl_last = (state == ST_WAIT) && conv_complete && (cpl_cnt + 2'd1 == cpl_target);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (load_en) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (stream_done) begin
                        state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (cpl_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // layer and mode are held for the whole life of the loaded buffer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer <= LAYER_WIDE;
            mode  <= PAD_NONE;
        end else if (load_en) begin
            layer <= load_layer;
            mode  <= load_mode;
        end
    end

    // pulses outside the wait state are ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cpl_cnt <= '0;
        end else if (load_en) begin
            cpl_cnt <= '0;
        end else if ((state == ST_WAIT) && conv_complete) begin
            cpl_cnt <= cpl_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_buffer <= 1'b0;
        end else begin
            free_buffer <= cpl_last;
        end
    end

endmodule

//--- rtl/noc_pkg.sv
`include "noc_consts.svh"

package noc_pkg;

    // routing pattern selection
    typedef enum logic {
        LAYER_WIDE   = 1'b0,
        LAYER_SHARED = 1'b1
    } layer_t;

    // zero bytes inserted at the low end of each line
    typedef enum logic [1:0] {
        PAD_NONE = 2'd0,
        PAD_ONE  = 2'd1,
        PAD_TWO  = 2'd2
    } pad_mode_t;

    // one buffer line, seen as bytes by the loader and as elements by the reader
    typedef union packed {
        logic [`NOC_LINE_BYTES-1:0][7:0]                bytes;
        logic [`NOC_ELEMS-1:0][`NOC_ELEM_BYTES*8-1:0]   elems;
    } line_word_t;

endpackage

//--- rtl/noc_consts.svh
`ifndef NOC_CONSTS_SVH
`define NOC_CONSTS_SVH

// buffer geometry
`define NOC_NUM_LINES   8
`define NOC_LINE_BYTES  16
`define NOC_ELEM_BYTES  4
`define NOC_ELEMS       4

// diagonal buses toward the PE array
`define NOC_NUM_DIAG    6

// line pointer width
`define NOC_PTR_W       3

// conv_complete pulses required before the buffer is released
`define NOC_CPL_WIDE    1
`define NOC_CPL_SHARED  2

`endif
